//--- rtl/cpu_config.svh
`ifndef cpu_config_svh
`define cpu_config_svh

`define CPU_DATA_WIDTH 32
`define CPU_REG_COUNT  32
`define CPU_RESET_PC   32'h0000_0000

// major opcodes, ir[30:25]
`define OP_TY_BASE 6'h20
`define OP_ADDI    6'h28
`define OP_XORI    6'h2B
`define OP_ORI     6'h2C
`define OP_MOVI    6'h22
`define OP_LWI     6'h02
`define OP_SWI     6'h0A
`define OP_TY_LS   6'h1C

// base type sub-opcodes, ir[4:0]
`define SUB_ADD   5'd0
`define SUB_SUB   5'd1
`define SUB_AND   5'd2
`define SUB_XOR   5'd3
`define SUB_OR    5'd4
`define SUB_SLLI  5'd8
`define SUB_SRLI  5'd9
`define SUB_ROTRI 5'd11

// load/store sub-opcodes, ir[7:0]
`define SUB_LW 8'h02
`define SUB_SW 8'h0A

`endif

//--- rtl/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_WIDTH-1:0] word_t;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_addr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [4:0] sub_op_t;

	typedef enum logic [2:0] {
		s_fetch,
		s_decode,
		s_execute,
		s_memory,
		s_writeback
	} state_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_rotr
	} alu_op_t;

	// operand b source
	typedef enum logic [1:0] {sel_reg, sel_shamt, sel_simm15, sel_uimm15} operand_sel_t;

	// register write source
	typedef enum logic [1:0] {wb_alu, wb_movi, wb_load} wb_sel_t;

endpackage

//--- rtl/ctrl_if.sv
`timescale 1ns/10ps

interface ctrl_if;

	logic load_ir;
	logic load_pc;
	logic latch_result;
	logic reg_write;
	cpu_pkg::alu_op_t alu_op;
	cpu_pkg::operand_sel_t operand_sel;
	cpu_pkg::wb_sel_t wb_sel;
	// address from ra + rb << sv instead of ra + imm15 << 2
	logic addr_indexed;

	modport control (
		output load_ir, load_pc, latch_result, reg_write,
		output alu_op, operand_sel, wb_sel, addr_indexed
	);

	modport path (
		input load_ir, load_pc, latch_result, reg_write,
		input alu_op, operand_sel, wb_sel, addr_indexed
	);

endinterface

//--- rtl/alu.sv
`timescale 1ns/10ps

module alu (
	input cpu_pkg::word_t operand_a,
	input cpu_pkg::word_t operand_b,
	input cpu_pkg::alu_op_t op,
	output cpu_pkg::word_t result
);

	logic [4:0] shift;
	logic [2*$bits(cpu_pkg::word_t)-1:0] rot_pair;

	assign shift = operand_b[4:0];

	// rotate right via a doubled word
	assign rot_pair = {operand_a, operand_a} >> shift;

	always_comb begin
		case (op)
			cpu_pkg::alu_add: result = operand_a + operand_b;
			cpu_pkg::alu_sub: result = operand_a - operand_b;
			cpu_pkg::alu_and: result = operand_a & operand_b;
			cpu_pkg::alu_or: result = operand_a | operand_b;
			cpu_pkg::alu_xor: result = operand_a ^ operand_b;
			cpu_pkg::alu_sll: result = operand_a << shift;
			cpu_pkg::alu_srl: result = operand_a >> shift;
			cpu_pkg::alu_rotr: result = rot_pair[$bits(cpu_pkg::word_t)-1:0];
			default: result = operand_a + operand_b;
		endcase
	end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module register_file (
	input logic clock,
	input logic reset,
	input cpu_pkg::reg_addr_t read_a_addr,
	input cpu_pkg::reg_addr_t read_b_addr,
	output cpu_pkg::word_t read_a,
	output cpu_pkg::word_t read_b,
	input logic write_enable,
	input cpu_pkg::reg_addr_t write_addr,
	input cpu_pkg::word_t write_data
);

	cpu_pkg::word_t regs [`CPU_REG_COUNT];

	// r0 is a normal register in this ISA
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (write_enable) begin
			regs[write_addr] <= write_data;
		end
	end

	// asynchronous reads
	assign read_a = regs[read_a_addr];
	assign read_b = regs[read_b_addr];

endmodule

//--- rtl/controller.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module controller (
	input logic clock,
	input logic reset,
	input cpu_pkg::word_t ir,
	ctrl_if.control ctl,
	output logic imem_req,
	input logic imem_ack,
	output logic dmem_req,
	output logic dmem_write,
	input logic dmem_ack
);

	cpu_pkg::state_t state;
	cpu_pkg::opcode_t opcode;
	cpu_pkg::sub_op_t sub_base;
	logic [7:0] sub_ls;

	// set once a request is answered, cleared when ack is seen low
	logic imem_wait_low;
	logic dmem_wait_low;
	logic imem_free;

	cpu_pkg::alu_op_t dec_alu_op;
	cpu_pkg::operand_sel_t dec_operand_sel;
	cpu_pkg::wb_sel_t dec_wb_sel;
	logic dec_reg_write;
	logic dec_indexed;
	logic mem_read;
	logic mem_write;
	logic mem_access;

	assign opcode = ir[30:25];
	assign sub_base = ir[4:0];
	assign sub_ls = ir[7:0];
	assign mem_access = mem_read || mem_write;
	assign imem_free = !imem_wait_low || !imem_ack;

	always_comb begin
		dec_alu_op = cpu_pkg::alu_add;
		dec_operand_sel = cpu_pkg::sel_reg;
		dec_wb_sel = cpu_pkg::wb_alu;
		dec_reg_write = 1'b0;
		dec_indexed = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		case (opcode)
			`OP_TY_BASE: begin
				dec_reg_write = 1'b1;
				case (sub_base)
					`SUB_ADD: dec_alu_op = cpu_pkg::alu_add;
					`SUB_SUB: dec_alu_op = cpu_pkg::alu_sub;
					`SUB_AND: dec_alu_op = cpu_pkg::alu_and;
					`SUB_XOR: dec_alu_op = cpu_pkg::alu_xor;
					`SUB_OR: dec_alu_op = cpu_pkg::alu_or;
					`SUB_SLLI: begin
						dec_alu_op = cpu_pkg::alu_sll;
						dec_operand_sel = cpu_pkg::sel_shamt;
					end
					`SUB_SRLI: begin
						dec_alu_op = cpu_pkg::alu_srl;
						dec_operand_sel = cpu_pkg::sel_shamt;
					end
					`SUB_ROTRI: begin
						dec_alu_op = cpu_pkg::alu_rotr;
						dec_operand_sel = cpu_pkg::sel_shamt;
					end
					// unknown sub-opcode is a no-op
					default: dec_reg_write = 1'b0;
				endcase
			end
			`OP_ADDI: begin
				dec_operand_sel = cpu_pkg::sel_simm15;
				dec_reg_write = 1'b1;
			end
			`OP_XORI: begin
				dec_alu_op = cpu_pkg::alu_xor;
				dec_operand_sel = cpu_pkg::sel_uimm15;
				dec_reg_write = 1'b1;
			end
			`OP_ORI: begin
				dec_alu_op = cpu_pkg::alu_or;
				dec_operand_sel = cpu_pkg::sel_uimm15;
				dec_reg_write = 1'b1;
			end
			`OP_MOVI: begin
				dec_wb_sel = cpu_pkg::wb_movi;
				dec_reg_write = 1'b1;
			end
			`OP_LWI: begin
				dec_wb_sel = cpu_pkg::wb_load;
				dec_reg_write = 1'b1;
				mem_read = 1'b1;
			end
			`OP_SWI: mem_write = 1'b1;
			`OP_TY_LS: begin
				dec_indexed = 1'b1;
				if (sub_ls == `SUB_LW) begin
					dec_wb_sel = cpu_pkg::wb_load;
					dec_reg_write = 1'b1;
					mem_read = 1'b1;
				end else if (sub_ls == `SUB_SW) begin
					mem_write = 1'b1;
				end
			end
			default: dec_reg_write = 1'b0;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= cpu_pkg::s_fetch;
			imem_req <= 1'b0;
			dmem_req <= 1'b0;
			dmem_write <= 1'b0;
			imem_wait_low <= 1'b0;
			dmem_wait_low <= 1'b0;
		end else begin
			if (imem_wait_low && !imem_ack)
				imem_wait_low <= 1'b0;
			case (state)
				cpu_pkg::s_fetch: begin
					if (imem_req && imem_ack) begin
						imem_req <= 1'b0;
						imem_wait_low <= 1'b1;
						state <= cpu_pkg::s_decode;
					end else if (!imem_req && imem_free) begin
						imem_req <= 1'b1;
					end
				end
				cpu_pkg::s_decode: state <= cpu_pkg::s_execute;
				cpu_pkg::s_execute: state <= cpu_pkg::s_memory;
				cpu_pkg::s_memory: begin
					if (!mem_access) begin
						state <= cpu_pkg::s_writeback;
					end else if (dmem_req) begin
						if (dmem_ack) begin
							dmem_req <= 1'b0;
							dmem_write <= 1'b0;
							dmem_wait_low <= 1'b1;
						end
					end else if (dmem_wait_low) begin
						if (!dmem_ack) begin
							dmem_wait_low <= 1'b0;
							state <= cpu_pkg::s_writeback;
						end
					end else if (!dmem_ack) begin
						dmem_req <= 1'b1;
						dmem_write <= mem_write;
					end
				end
				cpu_pkg::s_writeback: state <= cpu_pkg::s_fetch;
				default: state <= cpu_pkg::s_fetch;
			endcase
		end
	end

	assign ctl.load_ir = (state == cpu_pkg::s_fetch) && imem_req && imem_ack;
	// second pulse on a load ack captures the read data
	assign ctl.latch_result = (state == cpu_pkg::s_execute) ||
		((state == cpu_pkg::s_memory) && dmem_req && dmem_ack && mem_read);
	assign ctl.load_pc = (state == cpu_pkg::s_writeback);
	assign ctl.reg_write = (state == cpu_pkg::s_writeback) && dec_reg_write;
	assign ctl.alu_op = dec_alu_op;
	assign ctl.operand_sel = dec_operand_sel;
	assign ctl.wb_sel = dec_wb_sel;
	assign ctl.addr_indexed = dec_indexed;

	assert property (@(posedge clock) disable iff (reset)
		imem_req && !imem_ack |=> imem_req)
		else $error("imem_req dropped before imem_ack");

	assert property (@(posedge clock) disable iff (reset)
		dmem_req && !dmem_ack |=> dmem_req)
		else $error("dmem_req dropped before dmem_ack");

	assert property (@(posedge clock) disable iff (reset) dmem_write |-> dmem_req)
		else $error("dmem_write high without dmem_req");

	assert property (@(posedge clock) disable iff (reset)
		state inside {cpu_pkg::s_fetch, cpu_pkg::s_decode, cpu_pkg::s_execute,
			cpu_pkg::s_memory, cpu_pkg::s_writeback})
		else $error("illegal controller state %0d", state);

endmodule

//--- rtl/datapath.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module datapath (
	input logic clock,
	input logic reset,
	ctrl_if.path ctl,
	output cpu_pkg::word_t ir,
	output cpu_pkg::word_t imem_addr,
	input cpu_pkg::word_t imem_rdata,
	output cpu_pkg::word_t dmem_addr,
	output cpu_pkg::word_t dmem_wdata,
	input cpu_pkg::word_t dmem_rdata
);

	cpu_pkg::word_t pc;
	cpu_pkg::word_t result_reg;
	cpu_pkg::word_t addr_reg;
	cpu_pkg::word_t load_data;
	cpu_pkg::word_t read_a;
	cpu_pkg::word_t read_b;
	cpu_pkg::word_t simm15;
	cpu_pkg::word_t uimm15;
	cpu_pkg::word_t simm20;
	cpu_pkg::word_t shamt;
	cpu_pkg::word_t operand_b;
	cpu_pkg::word_t alu_result;
	cpu_pkg::word_t mem_offset;
	cpu_pkg::word_t wb_data;
	cpu_pkg::reg_addr_t rt;
	cpu_pkg::reg_addr_t ra;
	cpu_pkg::reg_addr_t rb;
	cpu_pkg::reg_addr_t read_b_addr;
	logic [1:0] sv;

	assign rt = ir[24:20];
	assign ra = ir[19:15];
	assign rb = ir[14:10];
	assign sv = ir[9:8];
	assign simm15 = {{(`CPU_DATA_WIDTH-15){ir[14]}}, ir[14:0]};
	assign uimm15 = {{(`CPU_DATA_WIDTH-15){1'b0}}, ir[14:0]};
	assign simm20 = {{(`CPU_DATA_WIDTH-20){ir[19]}}, ir[19:0]};
	assign shamt = {{(`CPU_DATA_WIDTH-5){1'b0}}, ir[14:10]};

	// port b reads rb while results latch, rt afterwards for store data
	assign read_b_addr = ctl.latch_result ? rb : rt;

	register_file regs (
		.clock(clock),
		.reset(reset),
		.read_a_addr(ra),
		.read_b_addr(read_b_addr),
		.read_a(read_a),
		.read_b(read_b),
		.write_enable(ctl.reg_write),
		.write_addr(rt),
		.write_data(wb_data)
	);

	always_comb begin
		case (ctl.operand_sel)
			cpu_pkg::sel_shamt: operand_b = shamt;
			cpu_pkg::sel_simm15: operand_b = simm15;
			cpu_pkg::sel_uimm15: operand_b = uimm15;
			default: operand_b = read_b;
		endcase
	end

	alu u_alu (
		.operand_a(read_a),
		.operand_b(operand_b),
		.op(ctl.alu_op),
		.result(alu_result)
	);

	assign mem_offset = ctl.addr_indexed ? (read_b << sv) : (simm15 << 2);

	always_comb begin
		case (ctl.wb_sel)
			cpu_pkg::wb_movi: wb_data = simm20;
			cpu_pkg::wb_load: wb_data = load_data;
			default: wb_data = result_reg;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= `CPU_RESET_PC;
			ir <= '0;
		end else begin
			if (ctl.load_ir)
				ir <= imem_rdata;
			if (ctl.load_pc)
				pc <= pc + 4;
		end
	end

	always_ff @(posedge clock) begin
		if (ctl.latch_result) begin
			result_reg <= alu_result;
			addr_reg <= read_a + mem_offset;
			if (ctl.wb_sel == cpu_pkg::wb_load)
				load_data <= dmem_rdata;
		end
	end

	assign imem_addr = pc;
	assign dmem_addr = addr_reg;
	assign dmem_wdata = read_b;

	assert property (@(posedge clock) disable iff (reset) imem_addr[1:0] == 2'b00)
		else $error("unaligned fetch address %h", imem_addr);

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
	input logic clock,
	input logic reset,
	output logic imem_req,
	output cpu_pkg::word_t imem_addr,
	input logic imem_ack,
	input cpu_pkg::word_t imem_rdata,
	output logic dmem_req,
	output logic dmem_write,
	output cpu_pkg::word_t dmem_addr,
	output cpu_pkg::word_t dmem_wdata,
	input logic dmem_ack,
	input cpu_pkg::word_t dmem_rdata
);

	cpu_pkg::word_t ir;

	ctrl_if ctl ();

	controller u_controller (
		.clock(clock),
		.reset(reset),
		.ir(ir),
		.ctl(ctl.control),
		.imem_req(imem_req),
		.imem_ack(imem_ack),
		.dmem_req(dmem_req),
		.dmem_write(dmem_write),
		.dmem_ack(dmem_ack)
	);

	datapath u_datapath (
		.clock(clock),
		.reset(reset),
		.ctl(ctl.path),
		.ir(ir),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_rdata(dmem_rdata)
	);

endmodule

//--- sim/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
	parameter int reset_cycles = 10
) (
	output logic clock,
	output logic reset
);

	// 20 ns period
	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

//--- sim/cpu_tb.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_tb;

	logic clock;
	logic reset;
	logic imem_req;
	cpu_pkg::word_t imem_addr;
	logic imem_ack = 1'b0;
	cpu_pkg::word_t imem_rdata = '0;
	logic dmem_req;
	logic dmem_write;
	cpu_pkg::word_t dmem_addr;
	cpu_pkg::word_t dmem_wdata;
	logic dmem_ack = 1'b0;
	cpu_pkg::word_t dmem_rdata = '0;

	cpu_pkg::word_t rom [64];
	cpu_pkg::word_t ram [64];
	cpu_pkg::word_t exp_addr [$];
	cpu_pkg::word_t exp_data [$];
	cpu_pkg::word_t next_fetch = `CPU_RESET_PC;
	logic [31:0] rand_state = 32'h90809a8f;
	logic [1:0] imem_delay = 2'd0;
	logic [1:0] dmem_delay = 2'd0;
	logic [2:0] imem_hold = 3'd0;
	logic [2:0] dmem_hold = 3'd0;
	int prog_len = 0;
	int fetches = 0;
	int checked = 0;
	int protocol_errors = 0;
	int value_errors = 0;
	int cycles;
	logic timed_out = 1'b0;

	clock_gen clk_rst (
		.clock(clock),
		.reset(reset)
	);

	cpu_top dut (
		.clock(clock),
		.reset(reset),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_ack(imem_ack),
		.imem_rdata(imem_rdata),
		.dmem_req(dmem_req),
		.dmem_write(dmem_write),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_ack(dmem_ack),
		.dmem_rdata(dmem_rdata)
	);

	function automatic logic [31:0] lcg(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic cpu_pkg::word_t reg_op(input int sub, input int rt, input int ra,
			input int rb);
		return {1'b0, `OP_TY_BASE, rt[4:0], ra[4:0], rb[4:0], 5'd0, sub[4:0]};
	endfunction

	function automatic cpu_pkg::word_t imm_op(input cpu_pkg::opcode_t op, input int rt,
			input int ra, input int imm);
		return {1'b0, op, rt[4:0], ra[4:0], imm[14:0]};
	endfunction

	function automatic cpu_pkg::word_t movi_op(input int rt, input int imm);
		return {1'b0, `OP_MOVI, rt[4:0], imm[19:0]};
	endfunction

	function automatic cpu_pkg::word_t ls_op(input logic [7:0] sub, input int rt, input int ra,
			input int rb, input int sv);
		return {1'b0, `OP_TY_LS, rt[4:0], ra[4:0], rb[4:0], sv[1:0], sub};
	endfunction

	task automatic emit(input cpu_pkg::word_t instr);
		rom[prog_len] = instr;
		prog_len++;
	endtask

	// SWI to the next free slot above r31 = 0x80
	task automatic store_and_expect(input int rt, input cpu_pkg::word_t data);
		int slot;
		slot = exp_addr.size();
		emit(imm_op(`OP_SWI, rt, 31, slot));
		exp_addr.push_back(32'h80 + 4 * slot);
		exp_data.push_back(data);
	endtask

	task automatic result_to_memory(input cpu_pkg::word_t instr, input cpu_pkg::word_t data);
		emit(instr);
		store_and_expect(6, data);
	endtask

	// both memory models, answered after 0 to 3 cycles, ack held 0 to 7 cycles past req
	always @(negedge clock) begin
		if (reset) begin
			imem_ack = 1'b0;
			dmem_ack = 1'b0;
		end else begin
			if (imem_req && !imem_ack) begin
				if (imem_delay != 2'd0) begin
					imem_delay = imem_delay - 2'd1;
				end else begin
					assert (imem_addr == next_fetch) else begin
						value_errors++;
						$display("error imem_addr got %h expected %h", imem_addr, next_fetch);
					end
					imem_rdata = rom[imem_addr[7:2]];
					imem_ack = 1'b1;
					next_fetch = next_fetch + 32'd4;
					fetches++;
					rand_state = lcg(rand_state);
					imem_hold = rand_state[31:29];
				end
			end else if (!imem_req && imem_ack) begin
				if (imem_hold != 3'd0) begin
					imem_hold = imem_hold - 3'd1;
				end else begin
					imem_ack = 1'b0;
					rand_state = lcg(rand_state);
					imem_delay = rand_state[31:30];
				end
			end
			if (dmem_req && !dmem_ack) begin
				if (dmem_delay != 2'd0) begin
					dmem_delay = dmem_delay - 2'd1;
				end else if (dmem_write) begin
					if (checked >= exp_addr.size()) begin
						value_errors++;
						$display("unexpected store of %h to %h", dmem_wdata, dmem_addr);
					end else begin
						assert (dmem_addr == exp_addr[checked]) else begin
							value_errors++;
							$display("error dmem_addr got %h expected %h", dmem_addr,
								exp_addr[checked]);
						end
						assert (dmem_wdata == exp_data[checked]) else begin
							value_errors++;
							$display("error dmem_wdata got %h expected %h", dmem_wdata,
								exp_data[checked]);
						end
					end
					ram[dmem_addr[7:2]] = dmem_wdata;
					checked++;
					dmem_ack = 1'b1;
					rand_state = lcg(rand_state);
					dmem_hold = rand_state[31:29];
				end else begin
					dmem_rdata = ram[dmem_addr[7:2]];
					dmem_ack = 1'b1;
					rand_state = lcg(rand_state);
					dmem_hold = rand_state[31:29];
				end
			end else if (!dmem_req && dmem_ack) begin
				if (dmem_hold != 3'd0) begin
					dmem_hold = dmem_hold - 3'd1;
				end else begin
					dmem_ack = 1'b0;
					rand_state = lcg(rand_state);
					dmem_delay = rand_state[31:30];
				end
			end
		end
	end

	assert property (@(posedge clock) $fell(reset) |-> !imem_req && !dmem_req && !dmem_write)
		else begin
			protocol_errors++;
			$display("request or write flag high right after reset");
		end

	assert property (@(posedge clock) disable iff (reset) imem_req && !imem_ack |=> imem_req)
		else begin
			protocol_errors++;
			$display("imem_req dropped before imem_ack arrived");
		end

	assert property (@(posedge clock) disable iff (reset) dmem_req && !dmem_ack |=> dmem_req)
		else begin
			protocol_errors++;
			$display("dmem_req dropped before dmem_ack arrived");
		end

	assert property (@(posedge clock) disable iff (reset) !imem_req && imem_ack |=> !imem_req)
		else begin
			protocol_errors++;
			$display("imem_req raised while imem_ack was still high");
		end

	assert property (@(posedge clock) disable iff (reset) !dmem_req && dmem_ack |=> !dmem_req)
		else begin
			protocol_errors++;
			$display("dmem_req raised while dmem_ack was still high");
		end

	initial begin
		// unused rom words stay opcode 0, a no-op
		for (int i = 0; i < 64; i++) begin
			rom[i] = '0;
			ram[i] = 32'hc0de_0000 | (i << 2);
		end

		emit(movi_op(31, 'h80));
		emit(movi_op(1, 'h12345));
		emit(movi_op(2, 'hffffb));
		emit(movi_op(14, 'h40));
		emit(movi_op(13, 4));
		store_and_expect(2, 32'hffff_fffb);
		emit(imm_op(`OP_ADDI, 3, 1, 'h7ff0));
		emit(imm_op(`OP_ORI, 4, 1, 'h4000));
		emit(imm_op(`OP_XORI, 5, 2, 'h4001));
		store_and_expect(3, 32'h0001_2335);
		store_and_expect(4, 32'h0001_6345);
		store_and_expect(5, 32'hffff_bffa);
		result_to_memory(reg_op(`SUB_ADD, 6, 1, 2), 32'h0001_2340);
		result_to_memory(reg_op(`SUB_SUB, 6, 1, 2), 32'h0001_234a);
		result_to_memory(reg_op(`SUB_AND, 6, 1, 2), 32'h0001_2341);
		result_to_memory(reg_op(`SUB_OR, 6, 1, 2), 32'hffff_ffff);
		result_to_memory(reg_op(`SUB_XOR, 6, 1, 2), 32'hfffe_dcbe);
		// shift amount sits in the rb field
		result_to_memory(reg_op(`SUB_SLLI, 6, 1, 1), 32'h0002_468a);
		result_to_memory(reg_op(`SUB_SLLI, 6, 2, 31), 32'h8000_0000);
		result_to_memory(reg_op(`SUB_SRLI, 6, 2, 1), 32'h7fff_fffd);
		result_to_memory(reg_op(`SUB_SRLI, 6, 2, 31), 32'h0000_0001);
		result_to_memory(reg_op(`SUB_ROTRI, 6, 1, 0), 32'h0001_2345);
		result_to_memory(reg_op(`SUB_ROTRI, 6, 1, 1), 32'h8000_91a2);
		result_to_memory(reg_op(`SUB_ROTRI, 6, 2, 31), 32'hffff_fff7);
		// loads from the fill area above r14 = 0x40
		result_to_memory(imm_op(`OP_LWI, 6, 14, 3), 32'hc0de_004c);
		result_to_memory(ls_op(`SUB_LW, 6, 14, 13, 0), 32'hc0de_0044);
		result_to_memory(ls_op(`SUB_LW, 6, 14, 13, 1), 32'hc0de_0048);
		result_to_memory(ls_op(`SUB_LW, 6, 14, 13, 2), 32'hc0de_0050);
		result_to_memory(ls_op(`SUB_LW, 6, 14, 13, 3), 32'hc0de_0060);
		emit(ls_op(`SUB_SW, 6, 31, 13, 3));
		exp_addr.push_back(32'h0000_00a0);
		exp_data.push_back(32'hc0de_0060);
		// undefined opcode, then undefined base sub-opcode, both aimed at r1
		emit({1'b0, 6'h3f, 5'd1, 5'd2, 15'h1234});
		emit(reg_op(31, 1, 2, 2));
		store_and_expect(1, 32'h0001_2345);

		cycles = 0;
		while (reset && cycles < 100) begin
			@(posedge clock);
			cycles++;
		end
		timed_out = reset;
		if (timed_out)
			$display("reset was never released");

		cycles = 0;
		while (!timed_out && checked < exp_addr.size() && cycles < 4000) begin
			@(posedge clock);
			cycles++;
		end
		if (!timed_out && checked < exp_addr.size()) begin
			timed_out = 1'b1;
			$display("timeout with %0d of %0d stores seen", checked, exp_addr.size());
		end

		// a few trailing no-ops keep the fetch check going
		cycles = 0;
		while (!timed_out && fetches < prog_len + 4 && cycles < 400) begin
			@(posedge clock);
			cycles++;
		end
		if (!timed_out && fetches < prog_len + 4) begin
			timed_out = 1'b1;
			$display("timeout, fetches stalled at %0d", fetches);
		end

		$display("protocol errors %0d, value errors %0d, stores checked %0d of %0d",
			protocol_errors, value_errors, checked, exp_addr.size());
		if (timed_out || protocol_errors != 0 || value_errors != 0)
			$display("Checks failed");
		else
			$display("All checks passed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/ctrl_if.sv
rtl/alu.sv
rtl/register_file.sv
rtl/controller.sv
rtl/datapath.sv
rtl/cpu_top.sv
sim/clock_gen.sv
sim/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP ?= cpu_tb
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG = All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
